/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_pkt -f sim.f -o tb_pkt
	./obj_dir/tb_pkt | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim.f */
+incdir+source
source/msg_pkg.sv
source/io_pkg.sv
source/msg_parser.sv
source/cmd_exec.sv
source/reply_framer.sv
source/pkt_top.sv
verification/pkt_props.sv
verification/tb_pkt.sv

/* source/cmd_exec.sv */
// Executes handshake and IO-control commands, holds the IO state and builds the reply status
`timescale 1ns/1ps
`default_nettype none
`include "pkt_consts.svh"

module cmd_exec (
   input  logic              clk,
   input  logic              i_reset,
   input  msg_pkg::msg_t     i_msg,
   input  logic              i_msg_done,
   input  io_pkg::io_vec_t   i_io_db,
   output io_pkg::io_vec_t   o_io_db,
   output io_pkg::io_vec_t   o_io_dir,
   output io_pkg::io_bank_t  o_io_bank,
   output msg_pkg::reply_t   o_reply,
   output logic              o_reply_start
);

   io_pkg::io_cfg_t cfg;
   io_pkg::io_cfg_t new_cfg;
   io_pkg::io_cfg_t cfg_nxt;
   io_pkg::io_vec_t msg_mask;
   io_pkg::io_vec_t msg_dir;
   io_pkg::io_vec_t msg_dat;
   msg_pkg::reply_t rep_nxt;
   logic            is_hs;
   logic            is_io;
   logic            do_set;
   logic            do_exe;
   logic            cnt_ok;
   logic            cnt_zero;

   assign is_hs = (i_msg.msg_type == `MSG_TYPE_HANDSHAKE);
   assign is_io = (i_msg.msg_type == `MSG_TYPE_IOCTRL);

   // Data words arrive as mask, dir, data
   assign msg_mask = i_msg.data[3*`IO_UNIT_NBIT-1 -: `IO_UNIT_NBIT];
   assign msg_dir  = i_msg.data[2*`IO_UNIT_NBIT-1 -: `IO_UNIT_NBIT];
   assign msg_dat  = i_msg.data[`IO_UNIT_NBIT-1:0];

   assign cnt_ok   = (i_msg.cnt == msg_pkg::frame_idx_t'(`IO_DATA_NUM));
   assign cnt_zero = (i_msg.cnt == '0);

   ////////////////////////////////////////////////////////////////////////////
   // New IO configuration

   always_comb begin
      new_cfg.mask = msg_mask;
      new_cfg.dir  = (cfg.dir & msg_mask) | (msg_dir & ~msg_mask);
      // Output bits take the message, input bits sample the pins
      new_cfg.data = (cfg.data & msg_mask) |
                     (~msg_mask & ((new_cfg.dir & msg_dat) | (~new_cfg.dir & i_io_db)));
   end

   // Mode decode and reply status
   always_comb begin
      rep_nxt.rtype = `MSG_TYPE_IOCTRL;
      rep_nxt.pf    = `MSG_FAIL;
      rep_nxt.code  = `MSG_FP_CODE_00;
      rep_nxt.baddr = 1'b1;
      do_set        = 1'b0;
      do_exe        = 1'b0;
      case (i_msg.mode)
         `MSG_MODE_SETDATA: begin
            if (cnt_ok) begin
               rep_nxt.pf   = i_msg.err ? `MSG_FAIL : `MSG_PASS;
               rep_nxt.code = i_msg.err ? `MSG_FP_CODE_03 : `MSG_FP_CODE_01;
               do_set       = !i_msg.err;
            end else begin
               rep_nxt.code = `MSG_FP_CODE_02;
            end
         end
         `MSG_MODE_EXEDATA: begin
            if (cnt_zero) begin
               rep_nxt.pf   = `MSG_PASS;
               rep_nxt.code = `MSG_FP_CODE_11;
               do_exe       = 1'b1;
            end else begin
               rep_nxt.code = `MSG_FP_CODE_12;
            end
         end
         `MSG_MODE_SEXDATA: begin
            if (cnt_ok) begin
               rep_nxt.pf   = i_msg.err ? `MSG_FAIL : `MSG_PASS;
               rep_nxt.code = i_msg.err ? `MSG_FP_CODE_23 : `MSG_FP_CODE_21;
               do_set       = !i_msg.err;
               do_exe       = !i_msg.err;
            end else begin
               rep_nxt.code = `MSG_FP_CODE_22;
            end
         end
         `MSG_MODE_RTN: begin
            rep_nxt.pf   = i_msg.err ? `MSG_FAIL : `MSG_PASS;
            rep_nxt.code = i_msg.err ? `MSG_FP_CODE_23 : `MSG_FP_CODE_21;
         end
         default: ;
      endcase

      cfg_nxt      = do_set ? new_cfg : cfg;
      rep_nxt.rdbk = {cfg_nxt.mask, cfg_nxt.dir, cfg_nxt.data};

      // Handshake always passes
      if (is_hs) begin
         rep_nxt.rtype = `MSG_TYPE_HANDSHAKE;
         rep_nxt.pf    = `MSG_PASS;
         rep_nxt.code  = `MSG_FP_CODE_01;
         rep_nxt.baddr = 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // IO state and pins

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_reply_start <= 1'b0;
         cfg           <= '0;
         o_io_db       <= '0;
         o_io_dir      <= '0;
         o_io_bank     <= '0;
      end else begin
         o_reply_start <= i_msg_done && (is_hs || is_io);
         if (i_msg_done && is_io) begin
            cfg <= cfg_nxt;
            if (do_exe) begin
               o_io_db   <= cfg_nxt.data;
               o_io_dir  <= cfg_nxt.dir;
               o_io_bank <= i_msg.bank;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_msg_done) begin
         o_reply <= rep_nxt;
      end
   end

endmodule

`default_nettype wire

/* source/io_pkg.sv */
// IO unit types and the stored IO configuration, used by the command executor
`default_nettype none
`include "pkt_consts.svh"

package io_pkg;

   typedef logic [`IO_UNIT_NBIT-1:0] io_vec_t;
   typedef logic [`IO_BANK_NBIT-1:0] io_bank_t;

   // Mask 1 keeps the bit, dir 1 is output
   typedef struct packed {
      io_vec_t mask;
      io_vec_t dir;
      io_vec_t data;
   } io_cfg_t;

endpackage

`default_nettype wire

/* source/msg_parser.sv */
// Receive FSM that turns the incoming host-link words into one decoded message record
`timescale 1ns/1ps
`default_nettype none
`include "pkt_consts.svh"

module msg_parser (
   input  logic           clk,
   input  logic           i_reset,
   input  logic           i_rx_sop,
   input  logic           i_rx_vd,
   input  msg_pkg::word_t i_rx_data,
   input  logic           i_rx_eop,
   output msg_pkg::msg_t  o_msg,
   output logic           o_msg_done
);

   msg_pkg::rx_state_e state;
   msg_pkg::hex_byte_t rx_byte;
   logic               rx_err;
   logic               rx_eol;
   logic               eol_end;

   always_comb begin
      rx_byte = msg_pkg::hex_to_byte(i_rx_data, rx_err);
   end

   assign rx_eol = msg_pkg::is_eol(i_rx_data);

   // Short command whose end-of-line word comes together with eop
   assign eol_end = i_rx_vd && rx_eol && i_rx_eop &&
                    (state == msg_pkg::RX_MODE || state == msg_pkg::RX_CHADDR);

   ////////////////////////////////////////////////////////////////////////////
   // Receive FSM

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state      <= msg_pkg::RX_IDLE;
         o_msg_done <= 1'b0;
      end else begin
         o_msg_done <= 1'b0;
         if (i_rx_sop) begin
            // Header may already sit on the sop cycle
            state <= (i_rx_vd && i_rx_data == `MSG_HEAD) ? msg_pkg::RX_TYPE : msg_pkg::RX_HEAD;
         end else if (i_rx_eop && (state == msg_pkg::RX_DATA ||
                                   state == msg_pkg::RX_END || eol_end)) begin
            o_msg_done <= 1'b1;
            state      <= msg_pkg::RX_IDLE;
         end else if (i_rx_vd) begin
            case (state)
               msg_pkg::RX_HEAD: begin
                  if (i_rx_data == `MSG_HEAD) begin
                     state <= msg_pkg::RX_TYPE;
                  end
               end
               msg_pkg::RX_TYPE: state <= msg_pkg::RX_MODE;
               msg_pkg::RX_MODE: state <= rx_eol ? msg_pkg::RX_END : msg_pkg::RX_CHADDR;
               msg_pkg::RX_CHADDR: state <= rx_eol ? msg_pkg::RX_END : msg_pkg::RX_DATA;
               msg_pkg::RX_DATA: begin
                  if (rx_eol) begin
                     state <= msg_pkg::RX_END;
                  end
               end
               default: ;
            endcase
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Message record

   always_ff @(posedge clk) begin
      if (i_rx_sop) begin
         o_msg <= '0;
      end else if (i_rx_vd && !rx_eol) begin
         case (state)
            msg_pkg::RX_TYPE: o_msg.msg_type <= i_rx_data;
            msg_pkg::RX_MODE: o_msg.mode <= i_rx_data;
            msg_pkg::RX_CHADDR: begin
               o_msg.chaddr <= i_rx_data;
               o_msg.bank   <= rx_byte;
               o_msg.err    <= o_msg.err | rx_err;
            end
            msg_pkg::RX_DATA: begin
               // Oldest byte ends up on top
               o_msg.data <= {o_msg.data[`MSG_DATA_MAX_NBIT-9:0], rx_byte};
               o_msg.cnt  <= o_msg.cnt + 1'b1;
               o_msg.err  <= o_msg.err | rx_err;
            end
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

/* source/msg_pkg.sv */
// Message format types, FSM states and hex/ASCII helpers shared by parser, executor and framer
`default_nettype none
`include "pkt_consts.svh"

package msg_pkg;

   typedef logic [`USB_DATA_NBIT-1:0]     word_t;
   typedef logic [`USB_DATA_NBIT/2-1:0]   hex_byte_t;
   typedef logic [`USB_ADDR_NBIT-1:0]     frame_idx_t;
   typedef logic [`MSG_DATA_MAX_NBIT-1:0] msg_data_t;

   // One decoded command
   typedef struct packed {
      word_t      msg_type;
      word_t      mode;
      word_t      chaddr;
      hex_byte_t  bank;
      msg_data_t  data;
      frame_idx_t cnt;
      logic       err;
   } msg_t;

   typedef enum logic [2:0] {
      RX_IDLE, RX_HEAD, RX_TYPE, RX_MODE, RX_CHADDR, RX_DATA, RX_END
   } rx_state_e;

   typedef enum logic [2:0] {
      TX_IDLE, TX_HEAD, TX_TYPE, TX_PF, TX_CODE, TX_CHADDR, TX_DATA, TX_END
   } tx_state_e;

   // Reply content handed to the framer
   typedef struct packed {
      word_t     rtype;
      word_t     pf;
      word_t     code;
      logic      baddr;
      msg_data_t rdbk;
   } reply_t;

   ////////////////////////////////////////////////////////////////////////////
   // Character conversion

   function automatic logic [3:0] char_to_nibble(input logic [7:0] c, output logic err);
      logic [7:0] v;
      err = 1'b0;
      v   = 8'h00;
      if (c >= "0" && c <= "9") begin
         v = c - "0";
      end else if (c >= "a" && c <= "f") begin
         v = c - "a" + 8'd10;
      end else if (c >= "A" && c <= "F") begin
         v = c - "A" + 8'd10;
      end else begin
         err = 1'b1;
      end
      return v[3:0];
   endfunction

   // Upper-case digits only
   function automatic logic [7:0] nibble_to_char(input logic [3:0] n);
      if (n < 4'd10) begin
         return {4'h0, n} + "0";
      end
      return {4'h0, n} + ("A" - 8'd10);
   endfunction

   // Low byte carries the high nibble
   function automatic hex_byte_t hex_to_byte(input word_t w, output logic err);
      logic      e_hi;
      logic      e_lo;
      hex_byte_t b;
      b[7:4] = char_to_nibble(w[7:0], e_hi);
      b[3:0] = char_to_nibble(w[15:8], e_lo);
      err    = e_hi | e_lo;
      return b;
   endfunction

   function automatic word_t byte_to_hex(input hex_byte_t b);
      word_t w;
      w[7:0]  = nibble_to_char(b[7:4]);
      w[15:8] = nibble_to_char(b[3:0]);
      return w;
   endfunction

   function automatic logic is_eol(input word_t w);
      return (w[7:0] == `MSG_END_N) || (w[7:0] == `MSG_END_R);
   endfunction

endpackage

`default_nettype wire

/* source/pkt_consts.svh */
// Word widths, message characters and status codes, included by the RTL and the testbench
`ifndef PKT_CONSTS_SVH
`define PKT_CONSTS_SVH

// Widths and counts
`define USB_DATA_NBIT      16
`define USB_ADDR_NBIT      4
`define MSG_DATA_MAX_NBIT  24
`define IO_UNIT_NBIT       8
`define IO_BANK_NBIT       8
`define IO_DATA_NUM        3

// Two characters per word, first character in the low byte
`define MSG_HEAD           16'h2340
`define MSG_END_N          8'h0A
`define MSG_END_R          8'h0D

// Command types
`define MSG_TYPE_HANDSHAKE 16'h3030
`define MSG_TYPE_IOCTRL    16'h3230

// IO modes
`define MSG_MODE_SETDATA   16'h3130
`define MSG_MODE_EXEDATA   16'h3230
`define MSG_MODE_SEXDATA   16'h3330
`define MSG_MODE_RTN       16'h3430

// Pass "OK", fail "NG"
`define MSG_PASS           16'h4B4F
`define MSG_FAIL           16'h474E

// Status codes
`define MSG_FP_CODE_00     16'h3030
`define MSG_FP_CODE_01     16'h3130
`define MSG_FP_CODE_02     16'h3230
`define MSG_FP_CODE_03     16'h3330
`define MSG_FP_CODE_11     16'h3131
`define MSG_FP_CODE_12     16'h3231
`define MSG_FP_CODE_21     16'h3132
`define MSG_FP_CODE_22     16'h3232
`define MSG_FP_CODE_23     16'h3332

`endif

/* source/pkt_top.sv */
// Top level of the host-link packet decoder, chaining parser, executor and reply framer
`timescale 1ns/1ps
`default_nettype none
`include "pkt_consts.svh"

module pkt_top (
   input  logic                    clk,
   input  logic                    i_reset,
   input  logic                    i_rx_sop,
   input  logic                    i_rx_vd,
   input  msg_pkg::word_t          i_rx_data,
   input  logic                    i_rx_eop,
   output logic                    o_tx_vd,
   output logic [`USB_ADDR_NBIT:0] o_tx_addr,
   output msg_pkg::word_t          o_tx_data,
   output logic                    o_tx_eop,
   input  io_pkg::io_vec_t         i_io_db,
   output io_pkg::io_vec_t         o_io_db,
   output io_pkg::io_vec_t         o_io_dir,
   output io_pkg::io_bank_t        o_io_bank
);

   msg_pkg::msg_t   msg;
   logic            msg_done;
   msg_pkg::reply_t reply;
   logic            reply_start;

   msg_parser u_parser (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_rx_sop   (i_rx_sop),
      .i_rx_vd    (i_rx_vd),
      .i_rx_data  (i_rx_data),
      .i_rx_eop   (i_rx_eop),
      .o_msg      (msg),
      .o_msg_done (msg_done)
   );

   cmd_exec u_exec (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_msg         (msg),
      .i_msg_done    (msg_done),
      .i_io_db       (i_io_db),
      .o_io_db       (o_io_db),
      .o_io_dir      (o_io_dir),
      .o_io_bank     (o_io_bank),
      .o_reply       (reply),
      .o_reply_start (reply_start)
   );

   // Channel word goes back to the host unchanged
   reply_framer u_framer (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_reply       (reply),
      .i_reply_start (reply_start),
      .i_chaddr      (msg.chaddr),
      .o_tx_vd       (o_tx_vd),
      .o_tx_addr     (o_tx_addr),
      .o_tx_data     (o_tx_data),
      .o_tx_eop      (o_tx_eop)
   );

endmodule

`default_nettype wire

/* source/reply_framer.sv */
// Transmit FSM that writes the reply frame word by word into the host-link TX buffer
`timescale 1ns/1ps
`default_nettype none
`include "pkt_consts.svh"

module reply_framer (
   input  logic                    clk,
   input  logic                    i_reset,
   input  msg_pkg::reply_t         i_reply,
   input  logic                    i_reply_start,
   input  msg_pkg::word_t          i_chaddr,
   output logic                    o_tx_vd,
   output logic [`USB_ADDR_NBIT:0] o_tx_addr,
   output msg_pkg::word_t          o_tx_data,
   output logic                    o_tx_eop
);

   localparam msg_pkg::frame_idx_t LAST_IDX = '1;

   msg_pkg::tx_state_e  state;
   msg_pkg::reply_t     rep;
   msg_pkg::frame_idx_t idx;
   msg_pkg::frame_idx_t cnt;
   msg_pkg::msg_data_t  shift;

   assign o_tx_addr = {rep.baddr, idx};

   ////////////////////////////////////////////////////////////////////////////
   // Transmit FSM

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state    <= msg_pkg::TX_IDLE;
         o_tx_vd  <= 1'b0;
         o_tx_eop <= 1'b0;
      end else begin
         o_tx_vd  <= (state != msg_pkg::TX_IDLE);
         o_tx_eop <= 1'b0;
         case (state)
            msg_pkg::TX_IDLE: begin
               if (i_reply_start) begin
                  state <= msg_pkg::TX_HEAD;
               end
            end
            msg_pkg::TX_HEAD: state <= msg_pkg::TX_TYPE;
            msg_pkg::TX_TYPE: state <= msg_pkg::TX_PF;
            msg_pkg::TX_PF:   state <= msg_pkg::TX_CODE;
            msg_pkg::TX_CODE: begin
               // Handshake reply stops after the code word
               if (rep.rtype == `MSG_TYPE_HANDSHAKE) begin
                  o_tx_eop <= 1'b1;
                  state    <= msg_pkg::TX_IDLE;
               end else begin
                  state <= msg_pkg::TX_CHADDR;
               end
            end
            msg_pkg::TX_CHADDR: state <= msg_pkg::TX_DATA;
            msg_pkg::TX_DATA: begin
               if (cnt == '0) begin
                  state <= msg_pkg::TX_END;
               end
            end
            msg_pkg::TX_END: begin
               if (idx == LAST_IDX - 1'b1) begin
                  o_tx_eop <= 1'b1;
                  state    <= msg_pkg::TX_IDLE;
               end
            end
            default: state <= msg_pkg::TX_IDLE;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Frame words

   always_ff @(posedge clk) begin
      if (state == msg_pkg::TX_HEAD) begin
         idx <= '0;
      end else if (state != msg_pkg::TX_IDLE) begin
         idx <= idx + 1'b1;
      end

      case (state)
         msg_pkg::TX_IDLE: begin
            if (i_reply_start) begin
               rep <= i_reply;
            end
         end
         msg_pkg::TX_HEAD: o_tx_data <= `MSG_HEAD;
         msg_pkg::TX_TYPE: o_tx_data <= rep.rtype;
         msg_pkg::TX_PF:   o_tx_data <= rep.pf;
         msg_pkg::TX_CODE: o_tx_data <= rep.code;
         msg_pkg::TX_CHADDR: begin
            o_tx_data <= i_chaddr;
            shift     <= rep.rdbk;
            cnt       <= msg_pkg::frame_idx_t'(`IO_DATA_NUM - 1);
         end
         msg_pkg::TX_DATA: begin
            // Mask first, then dir, then data
            o_tx_data <= msg_pkg::byte_to_hex(shift[`MSG_DATA_MAX_NBIT-1 -: 8]);
            shift     <= {shift[`MSG_DATA_MAX_NBIT-9:0], 8'h00};
            cnt       <= cnt - 1'b1;
         end
         msg_pkg::TX_END: begin
            // Counter wraps to all ones right after the data words
            o_tx_data <= (cnt == '1) ? {`MSG_END_N, `MSG_END_R} : '0;
            cnt       <= '0;
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* verification/pkt_props.sv */
// Concurrent checks on the packet decoder ports, bound into the top level for simulation
`timescale 1ns/1ps
`default_nettype none
`include "pkt_consts.svh"

module pkt_props (
   input logic             clk,
   input logic             i_reset,
   input logic             i_rx_eop,
   input logic             o_tx_vd,
   input logic             o_tx_eop,
   input io_pkg::io_vec_t  o_io_dir,
   input msg_pkg::word_t   msg_type
);

   eop_with_vd: assert property (@(posedge clk) disable iff (i_reset)
      o_tx_eop |-> o_tx_vd)
      else $error("tx eop seen without a valid word");

   // Only handshake and IO commands get a reply
   reply_latency: assert property (@(posedge clk) disable iff (i_reset)
      (i_rx_eop && (msg_type == `MSG_TYPE_HANDSHAKE || msg_type == `MSG_TYPE_IOCTRL))
      |-> ##4 $rose(o_tx_vd))
      else $error("first reply word not 4 cycles after rx eop");

   dir_after_eop: assert property (@(posedge clk) disable iff (i_reset)
      $changed(o_io_dir) |-> $past(i_rx_eop, 2))
      else $error("IO direction changed other than 2 cycles after rx eop");

endmodule

bind pkt_top pkt_props u_props (
   .clk      (clk),
   .i_reset  (i_reset),
   .i_rx_eop (i_rx_eop),
   .o_tx_vd  (o_tx_vd),
   .o_tx_eop (o_tx_eop),
   .o_io_dir (o_io_dir),
   .msg_type (msg.msg_type)
);

`default_nettype wire

/* verification/tb_pkt.sv */
// Directed testbench for the packet decoder top level, compiled with the sim.f file list
`timescale 1ns/1ps
`default_nettype none
`include "pkt_consts.svh"

module tb_pkt;

   localparam logic [`USB_DATA_NBIT-1:0] EOL_WORD = {`MSG_END_N, `MSG_END_R};
   localparam logic [`USB_DATA_NBIT-1:0] BAD_WORD = 16'h3047;
   localparam logic [`USB_DATA_NBIT-1:0] ODD_MODE = 16'h3930;
   localparam logic [`USB_DATA_NBIT-1:0] ODD_TYPE = 16'h3530;
   // Ten commands of under 40 cycles each leave a wide margin
   localparam int CYCLE_LIMIT = 2000;
   localparam int REPLY_WAIT  = 40;

   logic                         clk;
   logic                         i_reset;
   logic                         i_rx_sop;
   logic                         i_rx_vd;
   logic [`USB_DATA_NBIT-1:0]    i_rx_data;
   logic                         i_rx_eop;
   logic                         o_tx_vd;
   logic [`USB_ADDR_NBIT:0]      o_tx_addr;
   logic [`USB_DATA_NBIT-1:0]    o_tx_data;
   logic                         o_tx_eop;
   logic [`IO_UNIT_NBIT-1:0]     i_io_db;
   logic [`IO_UNIT_NBIT-1:0]     o_io_db;
   logic [`IO_UNIT_NBIT-1:0]     o_io_dir;
   logic [`IO_BANK_NBIT-1:0]     o_io_bank;

   // Captured reply frame
   logic [`USB_DATA_NBIT-1:0]    rx_data [0:15];
   logic [`USB_ADDR_NBIT:0]      rx_addr [0:15];
   logic                         rx_eop  [0:15];
   int                           rx_len;
   int                           rx_wait;
   logic [`USB_DATA_NBIT-1:0]    cmd_q [$];

   // Expected stored IO configuration and pin state
   logic [7:0]                   m_mask;
   logic [7:0]                   m_dir;
   logic [7:0]                   m_data;
   logic [7:0]                   p_db;
   logic [7:0]                   p_dir;
   logic [7:0]                   p_bank;

   logic [7:0]                   lfsr_state;
   int                           errors;
   int                           tests;
   int                           cycles;

   pkt_top dut0 (
      .clk       (clk),
      .i_reset   (i_reset),
      .i_rx_sop  (i_rx_sop),
      .i_rx_vd   (i_rx_vd),
      .i_rx_data (i_rx_data),
      .i_rx_eop  (i_rx_eop),
      .o_tx_vd   (o_tx_vd),
      .o_tx_addr (o_tx_addr),
      .o_tx_data (o_tx_data),
      .o_tx_eop  (o_tx_eop),
      .i_io_db   (i_io_db),
      .o_io_db   (o_io_db),
      .o_io_dir  (o_io_dir),
      .o_io_bank (o_io_bank)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("Run stopped after %0d cycles without reaching the end of the tests", cycles);
      $display("Test failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers

   // Taps 8,6,5,4
   function automatic logic lfsr_bit();
      logic fb;
      fb         = lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3];
      lfsr_state = {lfsr_state[6:0], fb};
      return fb;
   endfunction

   function automatic logic [7:0] rand_byte();
      logic [7:0] v;
      int         k;
      v = '0;
      for (k = 0; k < 8; k++) begin
         v = {v[6:0], lfsr_bit()};
      end
      return v;
   endfunction

   function automatic logic [7:0] hex_char(input logic [3:0] n);
      if (n > 4'd9) begin
         return 8'h41 + {4'h0, n} - 8'd10;
      end
      return 8'h30 + {4'h0, n};
   endfunction

   // High nibble character goes in the low byte
   function automatic logic [15:0] hex_word(input logic [7:0] b);
      return {hex_char(b[3:0]), hex_char(b[7:4])};
   endfunction

   task automatic report_mismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] want);
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, want);
      errors++;
   endtask

   task automatic finish_test(input string name, input int err_before);
      tests++;
      if (errors == err_before) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d errors", name, errors - err_before);
      end
   endtask

   task automatic drive_io_db(input logic [7:0] v);
      @(posedge clk);
      #1;
      i_io_db = v;
   endtask

   task automatic push_io_cmd(input logic [15:0] mode, input logic [7:0] bank);
      cmd_q.push_back(`MSG_HEAD);
      cmd_q.push_back(`MSG_TYPE_IOCTRL);
      cmd_q.push_back(mode);
      cmd_q.push_back(hex_word(bank));
   endtask

   // Sop on the header word, eop on the last word
   task automatic send_cmd();
      int n;
      int i;
      n = cmd_q.size();
      for (i = 0; i < n; i++) begin
         @(posedge clk);
         #1;
         i_rx_sop  = (i == 0);
         i_rx_vd   = 1'b1;
         i_rx_data = cmd_q[i];
         i_rx_eop  = (i == n - 1);
      end
      @(posedge clk);
      #1;
      i_rx_sop  = 1'b0;
      i_rx_vd   = 1'b0;
      i_rx_data = '0;
      i_rx_eop  = 1'b0;
      cmd_q.delete();
   endtask

   // Sampled at the falling edge, counting cycles from the eop edge
   task automatic collect_reply(input int limit);
      rx_len  = 0;
      rx_wait = 1;
      @(negedge clk);
      while (!o_tx_vd && rx_wait < limit) begin
         @(negedge clk);
         rx_wait++;
      end
      while (o_tx_vd && rx_len < 16) begin
         rx_data[rx_len] = o_tx_data;
         rx_addr[rx_len] = o_tx_addr;
         rx_eop[rx_len]  = o_tx_eop;
         rx_len++;
         if (o_tx_eop) begin
            break;
         end
         @(negedge clk);
      end
   endtask

   task automatic get_reply();
      collect_reply(REPLY_WAIT);
      if (rx_len == 0) begin
         $display("No reply came within %0d cycles, at %0t ns", REPLY_WAIT, $time);
         errors++;
      end else if (rx_wait != 4) begin
         report_mismatch("reply latency", rx_wait, 4);
      end
   endtask

   task automatic check_frame(input logic is_io, input logic [15:0] pf,
                              input logic [15:0] code, input logic [15:0] chaddr);
      logic [15:0] exp_w [0:15];
      int          n;
      int          i;
      n = is_io ? 16 : 4;
      for (i = 0; i < 16; i++) begin
         exp_w[i] = '0;
      end
      exp_w[0] = `MSG_HEAD;
      exp_w[1] = is_io ? `MSG_TYPE_IOCTRL : `MSG_TYPE_HANDSHAKE;
      exp_w[2] = pf;
      exp_w[3] = code;
      // Readback order is mask, dir, data
      exp_w[4] = chaddr;
      exp_w[5] = hex_word(m_mask);
      exp_w[6] = hex_word(m_dir);
      exp_w[7] = hex_word(m_data);
      exp_w[8] = EOL_WORD;
      if (rx_len != n) begin
         report_mismatch("reply length", rx_len, n);
      end
      for (i = 0; i < rx_len && i < n; i++) begin
         if (rx_data[i] != exp_w[i]) begin
            report_mismatch($sformatf("reply word %0d", i), rx_data[i], exp_w[i]);
         end
         if (rx_addr[i] != {is_io, 4'(i)}) begin
            report_mismatch($sformatf("address of word %0d", i), rx_addr[i], {is_io, 4'(i)});
         end
         if (rx_eop[i] != (i == n - 1)) begin
            report_mismatch($sformatf("eop on word %0d", i), rx_eop[i], (i == n - 1));
         end
      end
   endtask

   task automatic check_pins();
      if (o_io_db != p_db) begin
         report_mismatch("o_io_db", o_io_db, p_db);
      end
      if (o_io_dir != p_dir) begin
         report_mismatch("o_io_dir", o_io_dir, p_dir);
      end
      if (o_io_bank != p_bank) begin
         report_mismatch("o_io_bank", o_io_bank, p_bank);
      end
   endtask

   // Masked bits keep their state, unmasked input bits sample the pins
   task automatic model_config(input logic [7:0] mask, input logic [7:0] dir,
                               input logic [7:0] data, input logic [7:0] db);
      int b;
      for (b = 0; b < 8; b++) begin
         if (!mask[b]) begin
            m_dir[b]  = dir[b];
            m_data[b] = dir[b] ? data[b] : db[b];
         end
      end
      m_mask = mask;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests

   task automatic test_handshake();
      int err0;
      err0 = errors;
      cmd_q.push_back(`MSG_HEAD);
      cmd_q.push_back(`MSG_TYPE_HANDSHAKE);
      cmd_q.push_back(EOL_WORD);
      send_cmd();
      get_reply();
      check_frame(1'b0, `MSG_PASS, `MSG_FP_CODE_01, '0);
      check_pins();
      finish_test("handshake", err0);
   endtask

   task automatic test_set();
      int         err0;
      logic [7:0] bank;
      logic [7:0] mask;
      logic [7:0] dir;
      logic [7:0] data;
      logic [7:0] db;
      err0 = errors;
      bank = rand_byte();
      mask = rand_byte();
      dir  = rand_byte();
      data = rand_byte();
      db   = rand_byte();
      drive_io_db(db);
      push_io_cmd(`MSG_MODE_SETDATA, bank);
      cmd_q.push_back(hex_word(mask));
      cmd_q.push_back(hex_word(dir));
      cmd_q.push_back(hex_word(data));
      cmd_q.push_back(EOL_WORD);
      send_cmd();
      model_config(mask, dir, data, db);
      get_reply();
      check_frame(1'b1, `MSG_PASS, `MSG_FP_CODE_01, hex_word(bank));
      check_pins();
      finish_test("set", err0);
   endtask

   task automatic test_exe();
      int         err0;
      logic [7:0] bank;
      err0 = errors;
      bank = rand_byte();
      push_io_cmd(`MSG_MODE_EXEDATA, bank);
      cmd_q.push_back(EOL_WORD);
      send_cmd();
      p_db   = m_data;
      p_dir  = m_dir;
      p_bank = bank;
      get_reply();
      check_frame(1'b1, `MSG_PASS, `MSG_FP_CODE_11, hex_word(bank));
      check_pins();
      // Data words are not allowed here
      bank = rand_byte();
      push_io_cmd(`MSG_MODE_EXEDATA, bank);
      cmd_q.push_back(hex_word(rand_byte()));
      cmd_q.push_back(EOL_WORD);
      send_cmd();
      get_reply();
      check_frame(1'b1, `MSG_FAIL, `MSG_FP_CODE_12, hex_word(bank));
      check_pins();
      finish_test("exe", err0);
   endtask

   task automatic test_sex();
      int         err0;
      logic [7:0] bank;
      logic [7:0] mask;
      logic [7:0] dir;
      logic [7:0] data;
      logic [7:0] db;
      err0 = errors;
      bank = rand_byte();
      // Bit 0 masked, bit 7 an unmasked input
      mask = (rand_byte() & 8'h7E) | 8'h01;
      dir  = rand_byte() & 8'h7F;
      data = rand_byte();
      db   = rand_byte() | 8'h80;
      drive_io_db(db);
      push_io_cmd(`MSG_MODE_SEXDATA, bank);
      cmd_q.push_back(hex_word(mask));
      cmd_q.push_back(hex_word(dir));
      cmd_q.push_back(hex_word(data));
      cmd_q.push_back(EOL_WORD);
      send_cmd();
      model_config(mask, dir, data, db);
      p_db   = m_data;
      p_dir  = m_dir;
      p_bank = bank;
      get_reply();
      check_frame(1'b1, `MSG_PASS, `MSG_FP_CODE_21, hex_word(bank));
      check_pins();
      finish_test("set and execute", err0);
   endtask

   task automatic test_errors();
      int         err0;
      logic [7:0] bank;
      err0 = errors;
      bank = rand_byte();
      push_io_cmd(`MSG_MODE_SETDATA, bank);
      cmd_q.push_back(hex_word(rand_byte()));
      cmd_q.push_back(BAD_WORD);
      cmd_q.push_back(hex_word(rand_byte()));
      cmd_q.push_back(EOL_WORD);
      send_cmd();
      get_reply();
      check_frame(1'b1, `MSG_FAIL, `MSG_FP_CODE_03, hex_word(bank));
      check_pins();
      // Two data words instead of three
      push_io_cmd(`MSG_MODE_SETDATA, bank);
      cmd_q.push_back(hex_word(rand_byte()));
      cmd_q.push_back(hex_word(rand_byte()));
      cmd_q.push_back(EOL_WORD);
      send_cmd();
      get_reply();
      check_frame(1'b1, `MSG_FAIL, `MSG_FP_CODE_02, hex_word(bank));
      push_io_cmd(ODD_MODE, bank);
      cmd_q.push_back(hex_word(rand_byte()));
      cmd_q.push_back(hex_word(rand_byte()));
      cmd_q.push_back(hex_word(rand_byte()));
      cmd_q.push_back(EOL_WORD);
      send_cmd();
      get_reply();
      check_frame(1'b1, `MSG_FAIL, `MSG_FP_CODE_00, hex_word(bank));
      check_pins();
      finish_test("errors", err0);
   endtask

   task automatic test_rtn();
      int         err0;
      logic [7:0] bank;
      err0 = errors;
      bank = rand_byte();
      push_io_cmd(`MSG_MODE_RTN, bank);
      cmd_q.push_back(EOL_WORD);
      send_cmd();
      get_reply();
      check_frame(1'b1, `MSG_PASS, `MSG_FP_CODE_21, hex_word(bank));
      check_pins();
      // Unknown type gets no reply and no pin change even as a set and execute
      cmd_q.push_back(`MSG_HEAD);
      cmd_q.push_back(ODD_TYPE);
      cmd_q.push_back(`MSG_MODE_SEXDATA);
      cmd_q.push_back(hex_word(~p_bank));
      cmd_q.push_back(hex_word(rand_byte()));
      cmd_q.push_back(hex_word(rand_byte()));
      cmd_q.push_back(hex_word(rand_byte()));
      cmd_q.push_back(EOL_WORD);
      send_cmd();
      collect_reply(20);
      if (rx_len != 0) begin
         $display("A reply came for a command of unknown type, at %0t ns", $time);
         errors++;
      end
      check_pins();
      finish_test("readback and unknown type", err0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence

   initial begin
      i_reset    = 1'b1;
      i_rx_sop   = 1'b0;
      i_rx_vd    = 1'b0;
      i_rx_data  = '0;
      i_rx_eop   = 1'b0;
      i_io_db    = '0;
      lfsr_state = 8'd36;
      errors     = 0;
      tests      = 0;
      m_mask     = '0;
      m_dir      = '0;
      m_data     = '0;
      p_db       = '0;
      p_dir      = '0;
      p_bank     = '0;
      repeat (3) @(posedge clk);
      #1;
      i_reset = 1'b0;

      test_handshake();
      test_set();
      test_exe();
      test_sex();
      test_errors();
      test_rtn();

      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
